//--- Makefile
TOP := rv_core_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): rv_lite.f logic/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv_lite.f

# run from the project root so the trace path resolves
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f rv_lite.f

clean:
	rm -rf obj_dir

//--- logic/rv_alu.sv
// rv_lite alu: 64-bit add, subtract or pass operand b
`timescale 1ns/10ps

module rv_alu (
  input  rv_isa_pkg::xlen_t    a,
  input  rv_isa_pkg::xlen_t    b,
  input  rv_core_pkg::alu_op_e op,
  output rv_isa_pkg::xlen_t    result
);

  always_comb begin
    // results wrap mod 2^64, carry dropped
    case (op)
      rv_core_pkg::alu_add: begin
        result = a + b;
      end
      rv_core_pkg::alu_sub: begin
        result = a - b;
      end
      rv_core_pkg::alu_pass_b: begin
        // lui
        result = b;
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

//--- logic/rv_core_pkg.sv
// rv_lite core-internal types: alu operation, operand a select, store fsm state
package rv_core_pkg;

  // alu operation
  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    // lui passes the immediate straight through
    alu_pass_b
  } alu_op_e;

  // source of alu operand a
  typedef enum logic {
    opa_reg,
    // auipc adds to the pc
    opa_pc
  } opa_sel_e;

  // wishbone store master states
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    // ack taken, hold off until pc moves on
    st_done
  } store_state_e;

endpackage

//--- logic/rv_core_top.sv
// rv_lite core top: pc register, operand and writeback muxes, halt flags
`timescale 1ns/10ps

module rv_core_top #(
  parameter rv_isa_pkg::xlen_t reset_pc = 64'h8000_0000
) (
  input  logic                clk,
  input  logic                arst_n,
  output rv_isa_pkg::xlen_t   pc,
  input  rv_isa_pkg::inst_t   inst,
  output logic                wb_cyc,
  output logic                wb_stb,
  output rv_isa_pkg::xlen_t   wb_adr,
  output rv_isa_pkg::xlen_t   wb_dat_w,
  output rv_isa_pkg::wb_sel_t wb_sel,
  input  logic                wb_ack,
  output logic                halted,
  output logic                illegal
);

  rv_isa_pkg::reg_id_t   rd;
  rv_isa_pkg::reg_id_t   rs1;
  rv_isa_pkg::reg_id_t   rs2;
  rv_isa_pkg::xlen_t     imm;
  logic                  use_imm;
  rv_core_pkg::opa_sel_e opa_sel;
  rv_core_pkg::alu_op_e  alu_op;
  logic                  reg_wen;
  logic                  is_store;
  logic                  is_jal;
  logic                  is_ebreak;
  logic                  is_illegal;
  rv_isa_pkg::xlen_t     rdata_1;
  rv_isa_pkg::xlen_t     rdata_2;
  rv_isa_pkg::xlen_t     opa;
  rv_isa_pkg::xlen_t     opb;
  rv_isa_pkg::xlen_t     alu_result;
  rv_isa_pkg::xlen_t     pc_plus_4;
  rv_isa_pkg::xlen_t     next_pc;
  rv_isa_pkg::xlen_t     reg_wdata;
  logic                  store_req;
  logic                  stall;
  logic                  halt_now;
  logic                  pc_en;
  logic                  reg_we;

  rv_decoder u_decoder (
    .inst       (inst),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .imm        (imm),
    .use_imm    (use_imm),
    .opa_sel    (opa_sel),
    .alu_op     (alu_op),
    .reg_wen    (reg_wen),
    .is_store   (is_store),
    .is_jal     (is_jal),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  // no writes while a store waits or after halt
  assign reg_we    = reg_wen && !stall && !halted;
  // jal links the return address
  assign pc_plus_4 = pc + 64'd4;
  assign reg_wdata = is_jal ? pc_plus_4 : alu_result;

  rv_regfile u_regfile (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wdata   (reg_wdata),
    .wen     (reg_we),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand muxes
  assign opa = (opa_sel == rv_core_pkg::opa_pc) ? pc : rdata_1;
  assign opb = use_imm ? imm : rdata_2;

  rv_alu u_alu (
    .a      (opa),
    .b      (opb),
    .op     (alu_op),
    .result (alu_result)
  );

  assign store_req = is_store && !halted;

  // sd address from the alu, data straight from rs2
  rv_store_master u_store_master (
    .clk       (clk),
    .arst_n    (arst_n),
    .store_req (store_req),
    .addr      (alu_result),
    .data      (rdata_2),
    .stall     (stall),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_sel    (wb_sel),
    .wb_ack    (wb_ack)
  );

  // ebreak or bad word: pc must stay on it at the same edge the flag sets
  assign halt_now = is_ebreak || is_illegal;
  assign pc_en    = !stall && !halted && !halt_now;
  assign next_pc  = is_jal ? (pc + imm) : pc_plus_4;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (halt_now) begin
        halted <= 1'b1;
      end
      if (is_illegal) begin
        illegal <= 1'b1;
      end
    end
  end

endmodule

//--- logic/rv_decoder.sv
// rv_lite decoder: splits the instruction, builds the immediate, raises controls
`timescale 1ns/10ps

module rv_decoder (
  input  rv_isa_pkg::inst_t     inst,
  output rv_isa_pkg::reg_id_t   rd,
  output rv_isa_pkg::reg_id_t   rs1,
  output rv_isa_pkg::reg_id_t   rs2,
  output rv_isa_pkg::xlen_t     imm,
  output logic                  use_imm,
  output rv_core_pkg::opa_sel_e opa_sel,
  output rv_core_pkg::alu_op_e  alu_op,
  output logic                  reg_wen,
  output logic                  is_store,
  output logic                  is_jal,
  output logic                  is_ebreak,
  output logic                  is_illegal
);

  rv_isa_pkg::op_t   opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_isa_pkg::xlen_t imm_i;
  rv_isa_pkg::xlen_t imm_s;
  rv_isa_pkg::xlen_t imm_u;
  rv_isa_pkg::xlen_t imm_j;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // all immediates sign-extend from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // jal offset, scrambled bits, lsb always zero
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults: nothing written, nothing stored
    imm        = '0;
    use_imm    = 1'b0;
    opa_sel    = rv_core_pkg::opa_reg;
    alu_op     = rv_core_pkg::alu_add;
    reg_wen    = 1'b0;
    is_store   = 1'b0;
    is_jal     = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;
    case (opcode)
      rv_isa_pkg::op_imm: begin
        // only addi out of the op-imm group
        if (funct3 == rv_isa_pkg::funct3_add) begin
          imm     = imm_i;
          use_imm = 1'b1;
          reg_wen = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_isa_pkg::op_reg: begin
        if (funct3 == rv_isa_pkg::funct3_add && funct7 == rv_isa_pkg::funct7_add) begin
          reg_wen = 1'b1;
        end else if (funct3 == rv_isa_pkg::funct3_add &&
                     funct7 == rv_isa_pkg::funct7_sub) begin
          alu_op  = rv_core_pkg::alu_sub;
          reg_wen = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_isa_pkg::op_lui: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = rv_core_pkg::alu_pass_b;
        reg_wen = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        imm     = imm_u;
        use_imm = 1'b1;
        opa_sel = rv_core_pkg::opa_pc;
        reg_wen = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        // imm feeds the pc target, link comes from pc + 4 in the top
        imm     = imm_j;
        is_jal  = 1'b1;
        reg_wen = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        // alu forms rs1 + offset, rs2 is the data
        if (funct3 == rv_isa_pkg::funct3_sd) begin
          imm      = imm_s;
          use_imm  = 1'b1;
          is_store = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_isa_pkg::op_system: begin
        if (inst == rv_isa_pkg::ebreak_word) begin
          is_ebreak = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/rv_isa_pkg.sv
// rv64i subset instruction-set facts: word types, opcodes and funct fields
package rv_isa_pkg;

  // data and address word
  typedef logic [63:0] xlen_t;
  // raw instruction word
  typedef logic [31:0] inst_t;
  // register index
  typedef logic [4:0]  reg_id_t;
  // wishbone byte lanes
  typedef logic [7:0]  wb_sel_t;
  // major opcode field
  typedef logic [6:0]  op_t;

  // major opcodes of the supported set
  localparam op_t op_imm    = 7'b0010011;
  localparam op_t op_reg    = 7'b0110011;
  localparam op_t op_lui    = 7'b0110111;
  localparam op_t op_auipc  = 7'b0010111;
  localparam op_t op_jal    = 7'b1101111;
  localparam op_t op_store  = 7'b0100011;
  localparam op_t op_system = 7'b1110011;

  // funct3 of addi, add and sub
  localparam logic [2:0] funct3_add = 3'b000;
  // funct3 of sd
  localparam logic [2:0] funct3_sd  = 3'b011;

  // funct7 splits add from sub
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // ebreak is one fixed word, no fields
  localparam inst_t ebreak_word = 32'h0010_0073;

  localparam int num_regs = 32;

endpackage

//--- logic/rv_regfile.sv
// rv_lite register file: 32 x 64-bit, two async read ports, one write port
`timescale 1ns/10ps

module rv_regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  rv_isa_pkg::reg_id_t rs1,
  input  rv_isa_pkg::reg_id_t rs2,
  input  rv_isa_pkg::reg_id_t rd,
  input  rv_isa_pkg::xlen_t   wdata,
  input  logic                wen,
  output rv_isa_pkg::xlen_t   rdata_1,
  output rv_isa_pkg::xlen_t   rdata_2
);

  rv_isa_pkg::xlen_t regs [rv_isa_pkg::num_regs];

  // whole array cleared on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      // x0 is never written
      regs[rd] <= wdata;
    end
  end

  // combinational reads, x0 hardwired to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_store_master.sv
// rv_lite store master: wishbone classic write, stalls the core until ack
`timescale 1ns/10ps

module rv_store_master (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                store_req,
  input  rv_isa_pkg::xlen_t   addr,
  input  rv_isa_pkg::xlen_t   data,
  output logic                stall,
  output logic                wb_cyc,
  output logic                wb_stb,
  output rv_isa_pkg::xlen_t   wb_adr,
  output rv_isa_pkg::xlen_t   wb_dat_w,
  output rv_isa_pkg::wb_sel_t wb_sel,
  input  logic                wb_ack
);

  rv_core_pkg::store_state_e state;
  rv_core_pkg::store_state_e state_nxt;
  logic                      active;

  // bus is driven straight from the request in idle, no extra cycle
  assign active = (state == rv_core_pkg::st_wait) ||
                  (state == rv_core_pkg::st_idle && store_req);

  always_comb begin
    state_nxt = state;
    case (state)
      rv_core_pkg::st_idle: begin
        // zero-wait ack goes straight to done
        if (store_req) begin
          state_nxt = wb_ack ? rv_core_pkg::st_done : rv_core_pkg::st_wait;
        end
      end
      rv_core_pkg::st_wait: begin
        // no ack, keep waiting
        if (wb_ack) begin
          state_nxt = rv_core_pkg::st_done;
        end
      end
      rv_core_pkg::st_done: begin
        // pc moves on at this edge
        state_nxt = rv_core_pkg::st_idle;
      end
      default: begin
        state_nxt = rv_core_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rv_core_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // stall drops once done, so the same sd is not written twice
  assign stall    = active;
  assign wb_cyc   = active;
  assign wb_stb   = active;
  // pc and regs are frozen while stalled, so these hold steady
  assign wb_adr   = addr;
  assign wb_dat_w = data;
  // sd only, all eight lanes
  assign wb_sel   = active ? '1 : '0;

endmodule

//--- rv_lite.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_store_master.sv
logic/rv_core_top.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

//--- verif/rv_core_checker.sv
// rv_lite checker: wishbone write protocol and halt behavior assertions
`timescale 1ns/10ps

module rv_core_checker (
  input logic                clk,
  input logic                arst_n,
  input rv_isa_pkg::xlen_t   pc,
  input logic                wb_cyc,
  input logic                wb_stb,
  input rv_isa_pkg::xlen_t   wb_adr,
  input rv_isa_pkg::xlen_t   wb_dat_w,
  input rv_isa_pkg::wb_sel_t wb_sel,
  input logic                wb_ack,
  input logic                halted
);

  // request held without ack, bus fields must not move
  a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_sel)))
    else $error("wishbone address, data or select changed while waiting for ack");

  // strobe only inside a cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    wb_stb |-> wb_cyc)
    else $error("wishbone stb high without cyc");

  // sticky until reset
  a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> halted)
    else $error("halted fell without a reset");

  a_pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> $stable(pc))
    else $error("pc moved while the core was halted");

endmodule

//--- verif/rv_core_tb.sv
// rv_lite testbench acting as instruction memory and wishbone slave for the trace
`timescale 1ns/10ps

module rv_core_tb;

  localparam rv_isa_pkg::xlen_t reset_pc = 64'h8000_0000;

  logic                clk;
  logic                arst_n;
  rv_isa_pkg::xlen_t   pc;
  rv_isa_pkg::inst_t   inst;
  logic                wb_cyc;
  logic                wb_stb;
  rv_isa_pkg::xlen_t   wb_adr;
  rv_isa_pkg::xlen_t   wb_dat_w;
  rv_isa_pkg::wb_sel_t wb_sel;
  logic                wb_ack;
  logic                halted;
  logic                illegal;

  // program words of the current section keyed by address
  rv_isa_pkg::inst_t imem [rv_isa_pkg::xlen_t];
  rv_isa_pkg::xlen_t exp_adr [$];
  rv_isa_pkg::xlen_t exp_dat [$];
  rv_isa_pkg::xlen_t end_pc;
  logic              end_ill;
  int                fd;
  int                section;
  int                ack_delay;
  bit                pending;

  rv_core_top #(.reset_pc(reset_pc)) dut (
    .clk(clk), .arst_n(arst_n), .pc(pc), .inst(inst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_sel(wb_sel), .wb_ack(wb_ack), .halted(halted), .illegal(illegal)
  );

  bind rv_core_top rv_core_checker u_checker (
    .clk(clk), .arst_n(arst_n), .pc(pc), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack),
    .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // unlisted address reads as zero which decodes as illegal
  always_comb begin
    if (imem.exists(pc)) begin
      inst = imem[pc];
    end else begin
      inst = '0;
    end
  end

  task automatic report_mismatch(input string what);
    $display("FAILED at %0t ns: %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  // one clock then the wishbone slave on settled outputs
  task automatic clock_and_serve();
    @(posedge clk);
    #1;
    if (wb_ack) begin
      // single-cycle ack taken at this edge
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!pending) begin
        pending   = 1'b1;
        ack_delay = $urandom % 4;
      end
      if (ack_delay == 0) begin
        assert (exp_adr.size() > 0) else abort_run("bus write seen with no store left to expect");
        assert (wb_adr == exp_adr[0]) else
          report_mismatch($sformatf("store address %h, expected %h", wb_adr, exp_adr[0]));
        assert (wb_dat_w == exp_dat[0]) else
          report_mismatch($sformatf("store data %h, expected %h", wb_dat_w, exp_dat[0]));
        assert (wb_sel == 8'hff) else report_mismatch($sformatf("byte select %h", wb_sel));
        void'(exp_adr.pop_front());
        void'(exp_dat.pop_front());
        wb_ack = 1'b1;
      end else begin
        ack_delay--;
      end
    end
  endtask

  // reads trace lines up to a section break or the end of the file
  task automatic load_section();
    string             line;
    rv_isa_pkg::xlen_t col_1;
    rv_isa_pkg::xlen_t col_2;
    int                n;
    bit                done;
    done = 1'b0;
    imem.delete();
    exp_adr.delete();
    exp_dat.delete();
    while (!done && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        if (line[0] == "b") begin
          done = 1'b1;
        end else begin
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", col_1, col_2);
          assert (n == 2) else abort_run($sformatf("trace line cannot be parsed: %s", line));
          case (line[0])
            "p": imem[col_1] = col_2[31:0];
            "s": begin
              exp_adr.push_back(col_1);
              exp_dat.push_back(col_2);
            end
            "e": begin
              end_pc  = col_1;
              end_ill = col_2[0];
            end
            default: abort_run($sformatf("unknown tag in trace line: %s", line));
          endcase
        end
      end
    end
  endtask

  task automatic apply_reset();
    arst_n  = 1'b0;
    wb_ack  = 1'b0;
    pending = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    assert (pc == reset_pc) else report_mismatch($sformatf("pc %h after reset", pc));
    assert (!halted && !illegal && !wb_cyc && !wb_stb) else
      report_mismatch("status or bus outputs high during reset");
    arst_n = 1'b1;
  endtask

  task automatic run_section();
    int cycles;
    section++;
    apply_reset();
    cycles = 0;
    while (!halted) begin
      clock_and_serve();
      cycles++;
      if (cycles >= 2000) begin
        abort_run($sformatf("timeout in section %0d, core never halted", section));
      end
    end
    assert (exp_adr.size() == 0) else
      abort_run($sformatf("section %0d halted with stores still missing", section));
    assert (pc == end_pc) else report_mismatch($sformatf("halt pc %h, expected %h", pc, end_pc));
    assert (illegal == end_ill) else
      report_mismatch($sformatf("illegal flag %b, expected %b", illegal, end_ill));
    // quiet after halt with no bus cycle and pc held on the halting word
    repeat (10) begin
      clock_and_serve();
      assert (!wb_cyc && halted) else abort_run("bus cycle or halt drop after the core halted");
      assert (pc == end_pc) else report_mismatch($sformatf("pc moved to %h after halt", pc));
    end
  endtask

  initial begin
    void'($urandom(86));
    arst_n    = 1'b0;
    wb_ack    = 1'b0;
    pending   = 1'b0;
    ack_delay = 0;
    section   = 0;
    end_pc    = '0;
    end_ill   = 1'b0;
    fd = $fopen("verif/rv_core_trace.txt", "r");
    assert (fd != 0) else abort_run("cannot open verif/rv_core_trace.txt");
    while (!$feof(fd)) begin
      load_section();
      if (imem.size() > 0) begin
        run_section();
      end
    end
    $fclose(fd);
    assert (section == 2) else abort_run("trace did not hold two sections");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- verif/rv_core_trace.txt
# p <addr> <inst> program word | s <addr> <data> expected store
# e <pc> <illegal> expected end state | b section break
p 80000000 06400093
p 80000004 ff900113
p 80000008 002081b3
p 8000000c 40110233
p 80000010 00010537
p 80000014 00353023
p 80000018 00453423
p 8000001c 03700013
p 80000020 00053823
p 80000024 800002b7
p 80000028 00001317
p 8000002c 00553c23
p 80000030 02653023
p 80000034 008003ef
p 80000038 02153423
p 8000003c 02753823
p 80000040 00528433
p 80000044 02853c23
p 80000048 00100073
# 100 + -7, -7 - 100, x0 stays zero
s 10000 000000000000005d
s 10008 ffffffffffffff95
s 10010 0000000000000000
# lui 0x80000, auipc 0x1 at 80000028, jal link of 80000034
s 10018 ffffffff80000000
s 10020 0000000080001028
s 10030 0000000080000038
# lui value doubled, wraps mod 2^64
s 10038 ffffffff00000000
e 80000048 0
b
p 80000000 00500093
p 80000004 00103423
# ld is outside the supported set
p 80000008 0000b103
s 8 0000000000000005
e 80000008 1
